/* source/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// memory bus
`define WB_DATA_W           32

// two-way cache geometry
`define ICACHE_INDEX_W      6                           // 64 sets
`define ICACHE_WORD_OFF_W   4                           // 16 words, 64 bytes per line
`define ICACHE_TAG_W        20
`define ICACHE_OFF_W        (`ICACHE_WORD_OFF_W + 2)    // byte offset inside a line
`define ICACHE_LINE_W       ((1 << `ICACHE_WORD_OFF_W) * `WB_DATA_W)

`endif

/* source/icache_pkg.sv */
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ICACHE_LINE_W-1:0] line_t;
    typedef logic [`ICACHE_TAG_W-1:0]  tag_t;

    // pipeline fetch request
    typedef struct packed {
        logic [`WB_DATA_W-1:0] addr;
        logic                  uncached;
    } fetch_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`WB_DATA_W-1:0]   addr;    // echo of the request
        logic [2*`WB_DATA_W-1:0] data;    // aligned instruction pair
        logic                    fault;   // misaligned fetch
    } fetch_rsp_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`WB_DATA_W-1:0] adr;
    } wb_m2s_t;

    typedef struct packed {
        logic                  ack;
        logic [`WB_DATA_W-1:0] dat;
    } wb_s2m_t;

    // refill command to the line fetcher
    typedef struct packed {
        logic [`WB_DATA_W-1:0] addr;      // line aligned, or pair aligned if uncached
        logic                  uncached;
    } fill_req_t;

endpackage

/* source/sdp_ram.sv */
`timescale 1ns/1ps

module sdp_ram #(
    parameter type word_t = logic [31:0],
    parameter int  addr_w = 6
) (
    input  logic              clk,
    input  logic              i_we,
    input  logic [addr_w-1:0] i_waddr,
    input  word_t             i_wdata,
    input  logic [addr_w-1:0] i_raddr,
    output word_t             o_rdata
);

    word_t mem [0:(1 << addr_w)-1];

    // registered read, a same-address write shows up one access later
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

/* source/icache_way.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_way (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`ICACHE_INDEX_W-1:0] i_raddr_index,
    input  icache_pkg::tag_t           i_lookup_tag,
    input  logic                       i_we,
    input  logic [`ICACHE_INDEX_W-1:0] i_waddr_index,
    input  icache_pkg::tag_t           i_wtag,
    input  icache_pkg::line_t          i_wline,
    input  logic                       i_inval_all,
    output logic                       o_hit,
    output icache_pkg::line_t          o_line
);
    import icache_pkg::*;

    localparam int num_sets = 1 << `ICACHE_INDEX_W;

    logic [num_sets-1:0] valid_q;      // flops so a barrier clears all at once
    logic                valid_rd_q;   // valid bit of the set being read
    tag_t                tag_rd;

    sdp_ram #(.word_t(tag_t), .addr_w(`ICACHE_INDEX_W)) u_tag_ram (
        .clk     (clk),
        .i_we    (i_we),
        .i_waddr (i_waddr_index),
        .i_wdata (i_wtag),
        .i_raddr (i_raddr_index),
        .o_rdata (tag_rd)
    );

    sdp_ram #(.word_t(line_t), .addr_w(`ICACHE_INDEX_W)) u_line_ram (
        .clk     (clk),
        .i_we    (i_we),
        .i_waddr (i_waddr_index),
        .i_wdata (i_wline),
        .i_raddr (i_raddr_index),
        .o_rdata (o_line)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            if (i_inval_all) begin
                valid_q <= '0;
            end else if (i_we) begin
                valid_q[i_waddr_index] <= 1'b1;
            end
            valid_rd_q <= valid_q[i_raddr_index] & ~i_inval_all;   // same timing as tag read
        end
    end

    assign o_hit = valid_rd_q && (tag_rd == i_lookup_tag);

endmodule

/* source/wb_line_fetcher.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module wb_line_fetcher (
    input  logic                  clk,
    input  logic                  rstn,
    input  icache_pkg::fill_req_t i_fill,
    input  logic                  i_fill_start,
    output logic                  o_fill_done,
    output icache_pkg::line_t     o_line,
    output icache_pkg::wb_m2s_t   o_wb,
    input  icache_pkg::wb_s2m_t   i_wb
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        F_IDLE,
        F_READ,    // cyc/stb held until ack
        F_DONE     // one cycle, return buffer complete
    } fetch_state_e;

    fetch_state_e                  state_q;
    logic [`ICACHE_WORD_OFF_W-1:0] beat_q;
    logic [`ICACHE_WORD_OFF_W-1:0] last_beat_q;
    logic [`WB_DATA_W-1:0]         adr_q;
    logic                          beat_ack;

    assign beat_ack = (state_q == F_READ) && i_wb.ack;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q     <= F_IDLE;
            beat_q      <= '0;
            last_beat_q <= '0;
            adr_q       <= '0;
        end else begin
            case (state_q)
                F_IDLE: begin
                    if (i_fill_start) begin
                        state_q     <= F_READ;
                        beat_q      <= '0;
                        adr_q       <= i_fill.addr;
                        last_beat_q <= i_fill.uncached ? 'd1 : '1;   // pair or whole line
                    end
                end
                F_READ: begin
                    if (beat_ack) begin
                        beat_q <= beat_q + 1'b1;
                        adr_q  <= adr_q + (`WB_DATA_W / 8);      // next word
                        if (beat_q == last_beat_q) begin
                            state_q <= F_DONE;
                        end
                    end
                end
                default: begin
                    state_q <= F_IDLE;
                end
            endcase
        end
    end

    // return buffer, word lands in its beat slot
    always_ff @(posedge clk) begin
        if (beat_ack) begin
            o_line[beat_q*`WB_DATA_W +: `WB_DATA_W] <= i_wb.dat;
        end
    end

    assign o_fill_done = (state_q == F_DONE);

    always_comb begin
        o_wb.cyc = (state_q == F_READ);
        o_wb.stb = (state_q == F_READ);
        o_wb.we  = 1'b0;   // read only master
        o_wb.adr = adr_q;
    end

endmodule

/* source/icache.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache (
    input  logic                   clk,
    input  logic                   rstn,
    input  icache_pkg::fetch_req_t i_req,
    input  logic                   i_req_valid,
    output logic                   o_req_ready,
    output icache_pkg::fetch_rsp_t o_rsp,
    input  logic                   i_flush,
    input  logic                   i_ibar,
    output icache_pkg::fill_req_t  o_fill,
    output logic                   o_fill_start,
    input  logic                   i_fill_done,
    input  icache_pkg::line_t      i_fill_line
);
    import icache_pkg::*;

    localparam int idx_lo = `ICACHE_OFF_W;
    localparam int tag_lo = `ICACHE_OFF_W + `ICACHE_INDEX_W;
    localparam int pair_w = 2 * `WB_DATA_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_REFILL
    } state_e;

    state_e                            state_q;
    state_e                            state_d;
    fetch_req_t                        req_q;         // request buffer
    logic                              pending_q;     // response still owed
    logic                              run_q;         // first cycle out of reset
    logic                              fill_start_q;
    logic [(1<<`ICACHE_INDEX_W)-1:0]   lru_q;         // bit names the way to replace next

    logic [`ICACHE_INDEX_W-1:0]        req_index;
    tag_t                              req_tag;
    logic [1:0]                        way_hit;
    logic [1:0]                        way_we;
    line_t                             way_line [2];
    logic                              hit_way;
    logic                              victim;
    logic                              fault;
    logic                              accept;
    logic                              inval_all;
    logic                              refill_we;
    logic                              lookup_hit;
    logic                              lookup_miss;
    logic                              rsp_now;
    line_t                             sel_line;
    logic [pair_w-1:0]                 pair;

    assign req_index   = req_q.addr[idx_lo +: `ICACHE_INDEX_W];
    assign req_tag     = req_q.addr[tag_lo +: `ICACHE_TAG_W];
    assign fault       = (req_q.addr[1:0] != 2'b00);
    assign hit_way     = way_hit[1] & ~way_hit[0];   // way 0 wins a double hit
    assign victim      = lru_q[req_index];
    assign inval_all   = i_ibar && (state_q == S_IDLE);
    assign refill_we   = (state_q == S_REFILL) && !req_q.uncached;
    assign way_we      = refill_we ? {victim, ~victim} : 2'b00;
    assign lookup_hit  = (state_q == S_LOOKUP) && !fault && !req_q.uncached && (|way_hit);
    assign lookup_miss = (state_q == S_LOOKUP) && !fault && (req_q.uncached || !(|way_hit));
    assign accept      = i_req_valid && o_req_ready;

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_way u_way (
            .clk           (clk),
            .rstn          (rstn),
            .i_raddr_index (i_req.addr[idx_lo +: `ICACHE_INDEX_W]),   // read on acceptance
            .i_lookup_tag  (req_tag),
            .i_we          (way_we[w]),
            .i_waddr_index (req_index),
            .i_wtag        (req_tag),
            .i_wline       (i_fill_line),
            .i_inval_all   (inval_all),
            .o_hit         (way_hit[w]),
            .o_line        (way_line[w])
        );
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (lookup_miss) begin
                    state_d = S_MISS;
                end else begin
                    state_d = accept ? S_LOOKUP : S_IDLE;   // hit or fault answered
                end
            end
            S_MISS: begin
                if (i_fill_done) begin
                    state_d = S_REFILL;
                end
            end
            default: begin
                state_d = accept ? S_LOOKUP : S_IDLE;
            end
        endcase
    end

    // response slot and ready
    always_comb begin
        rsp_now     = 1'b0;
        o_req_ready = 1'b0;
        sel_line    = i_fill_line;
        case (state_q)
            S_IDLE: begin
                o_req_ready = run_q;
            end
            S_LOOKUP: begin
                sel_line = way_line[hit_way];
                if (fault || lookup_hit) begin
                    rsp_now     = 1'b1;
                    o_req_ready = 1'b1;
                end
            end
            S_REFILL: begin
                rsp_now     = 1'b1;
                o_req_ready = 1'b1;
            end
            default: begin
                rsp_now = 1'b0;
            end
        endcase
    end

    // pair select by address bits 5:3, uncached pair sits at the bottom
    assign pair = req_q.uncached ? i_fill_line[pair_w-1:0]
                                 : sel_line[req_q.addr[idx_lo-1:3]*pair_w +: pair_w];

    always_comb begin
        o_rsp.valid = rsp_now && pending_q;
        o_rsp.addr  = req_q.addr;
        o_rsp.data  = fault ? '0 : pair;
        o_rsp.fault = fault;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q      <= S_IDLE;
            req_q        <= '0;
            pending_q    <= 1'b0;
            run_q        <= 1'b0;
            fill_start_q <= 1'b0;
            lru_q        <= '0;
        end else begin
            state_q      <= state_d;
            run_q        <= 1'b1;
            fill_start_q <= lookup_miss;   // fetcher is idle in the first miss cycle
            if (accept) begin
                req_q <= i_req;
            end
            // a new request outranks a flush in the same cycle
            if (accept) begin
                pending_q <= 1'b1;
            end else if (i_flush || o_rsp.valid) begin
                pending_q <= 1'b0;
            end
            if (lookup_hit) begin
                lru_q[req_index] <= ~hit_way;
            end else if (refill_we) begin
                lru_q[req_index] <= ~victim;
            end
        end
    end

    assign o_fill.addr     = req_q.uncached ? {req_q.addr[31:3], 3'b000}
                                            : {req_q.addr[31:idx_lo], {idx_lo{1'b0}}};
    assign o_fill.uncached = req_q.uncached;
    assign o_fill_start    = fill_start_q;

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  icache_pkg::fetch_req_t i_req,
    input  logic                   i_req_valid,
    output logic                   o_req_ready,
    output icache_pkg::fetch_rsp_t o_rsp,
    input  logic                   i_flush,
    input  logic                   i_ibar,
    output icache_pkg::wb_m2s_t    o_wb,
    input  icache_pkg::wb_s2m_t    i_wb
);
    import icache_pkg::*;

    fill_req_t fill;
    logic      fill_start;
    logic      fill_done;
    line_t     fill_line;   // return buffer of the fetcher

    icache u_icache (
        .clk          (clk),
        .rstn         (rstn),
        .i_req        (i_req),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .o_rsp        (o_rsp),
        .i_flush      (i_flush),
        .i_ibar       (i_ibar),
        .o_fill       (fill),
        .o_fill_start (fill_start),
        .i_fill_done  (fill_done),
        .i_fill_line  (fill_line)
    );

    wb_line_fetcher u_fetcher (
        .clk          (clk),
        .rstn         (rstn),
        .i_fill       (fill),
        .i_fill_start (fill_start),
        .o_fill_done  (fill_done),
        .o_line       (fill_line),
        .o_wb         (o_wb),
        .i_wb         (i_wb)
    );

endmodule

/* test/wb_rom_model.sv */
`timescale 1ns/1ps

module wb_rom_model #(
    parameter logic [31:0] pattern = 32'h5a3c_96e1
) (
    input  logic                clk,
    input  logic                rstn,
    input  icache_pkg::wb_m2s_t i_wb,
    output icache_pkg::wb_s2m_t o_wb,
    output logic [31:0]         o_beats     // acknowledged beats since reset
);
    import icache_pkg::*;

    logic [1:0] wait_q;   // cycles left before the next ack

    always @(posedge clk) begin : slave
        logic [31:0] rnd;
        if (!rstn) begin
            o_wb    <= '0;
            wait_q  <= '0;
            o_beats <= '0;
        end else begin
            o_wb.ack <= 1'b0;   // ack lasts one cycle
            if (i_wb.cyc && i_wb.stb && !o_wb.ack) begin
                if (wait_q == 2'd0) begin
                    rnd = $urandom_range(3, 0);
                    o_wb.ack <= 1'b1;
                    o_wb.dat <= i_wb.adr ^ pattern;   // contents follow the whole address
                    o_beats  <= o_beats + 1;
                    wait_q   <= rnd[1:0];
                end else begin
                    wait_q <= wait_q - 1'b1;
                end
            end
        end
    end

endmodule

/* test/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;
    import icache_pkg::*;

    localparam logic [31:0] pattern    = 32'h5a3c_96e1;
    localparam logic [1:0]  K_ANY      = 2'd0;   // no timing expectation
    localparam logic [1:0]  K_HIT      = 2'd1;   // one cycle and no bus traffic
    localparam logic [1:0]  K_LINE     = 2'd2;
    localparam logic [1:0]  K_PAIR     = 2'd3;
    localparam int          n_rand     = 48;
    localparam int          n_req      = n_rand + 14;
    localparam int          timeout_ns = n_req * 40 * 40 + 16 * 40;
    localparam int          drain_max  = 200;    // cycles, well above one line refill

    typedef struct packed {
        logic [31:0] addr;
        logic [63:0] data;
        logic        fault;
        logic [1:0]  kind;
        logic [31:0] acc_cycle;
        logic [31:0] beats;       // bus beats seen at acceptance
    } expect_t;

    logic        clk = 1'b0;
    logic        rstn;
    fetch_req_t  req;
    logic        req_valid;
    logic        req_ready;
    fetch_rsp_t  rsp;
    logic        flush;
    logic        ibar;
    wb_m2s_t     wb_m2s;
    wb_s2m_t     wb_s2m;
    logic [31:0] beats;
    logic [1:0]  cur_kind;
    logic [31:0] first_adr;       // address of the latest bus cycle's first beat
    logic        cyc_d = 1'b0;
    int          cycle = 0;
    int          mismatches = 0;
    int          protocol_errors = 0;
    int          seed_val;
    expect_t     exp_q [$];

    always #20 clk = ~clk;

    fetch_top i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .i_req       (req),
        .i_req_valid (req_valid),
        .o_req_ready (req_ready),
        .o_rsp       (rsp),
        .i_flush     (flush),
        .i_ibar      (ibar),
        .o_wb        (wb_m2s),
        .i_wb        (wb_s2m)
    );

    wb_rom_model #(.pattern(pattern)) u_rom (
        .clk     (clk),
        .rstn    (rstn),
        .i_wb    (wb_m2s),
        .o_wb    (wb_s2m),
        .o_beats (beats)
    );

    function automatic logic [63:0] expected_pair(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ pattern, base ^ pattern};   // lower address in the low word
    endfunction

    task automatic report_bus_error(input string what);
        protocol_errors++;
        $display("Bus rule broken at %0t ns: %s", $time, what);
    endtask

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rstn)
        wb_m2s.stb |-> wb_m2s.cyc)
        else report_bus_error("stb was high outside a bus cycle");
    a_read_only: assert property (@(posedge clk) disable iff (!rstn)
        wb_m2s.cyc |-> !wb_m2s.we)
        else report_bus_error("we was raised during a fetch");
    a_adr_hold: assert property (@(posedge clk) disable iff (!rstn)
        (wb_m2s.stb && !wb_s2m.ack) |=> (wb_m2s.stb && $stable(wb_m2s.adr)))
        else report_bus_error("stb or address changed before ack");
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rstn)
        wb_s2m.ack |-> (wb_m2s.cyc && wb_m2s.stb))
        else report_bus_error("ack arrived with no strobe");
    a_reset_quiet: assert property (@(posedge clk)
        (!rstn && cycle > 0) |-> !(rsp.valid || req_ready || wb_m2s.cyc))
        else report_bus_error("outputs were active during reset");

    always @(posedge clk) begin : monitor
        expect_t     e;
        int          exp_beats;
        logic [31:0] exp_adr;
        if (rstn && rsp.valid) begin
            assert (exp_q.size() > 0) else begin
                protocol_errors++;
                $display("A response for %h arrived with no request waiting for it", rsp.addr);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                assert (rsp.addr == e.addr && rsp.fault == e.fault && rsp.data == e.data) else begin
                    mismatches++;
                    $display("MISMATCH at %0t ns: got addr %h fault %b data %h", $time,
                             rsp.addr, rsp.fault, rsp.data);
                    $display("MISMATCH at %0t ns: want addr %h fault %b data %h", $time,
                             e.addr, e.fault, e.data);
                end
                // any answer without bus traffic is a hit and owes one cycle latency
                if (e.kind == K_HIT || (e.kind == K_ANY && beats == e.beats)) begin
                    assert (cycle - e.acc_cycle == 1 && beats == e.beats) else begin
                        mismatches++;
                        $display("MISMATCH at %0t ns: %h latency %0d beats %0d, want 1 and 0",
                                 $time, e.addr, cycle - e.acc_cycle, beats - e.beats);
                    end
                end
                if (e.kind == K_LINE || e.kind == K_PAIR) begin
                    exp_beats = (e.kind == K_LINE) ? 16 : 2;
                    exp_adr   = (e.kind == K_LINE) ? {e.addr[31:6], 6'd0} : {e.addr[31:3], 3'd0};
                    assert (beats - e.beats == exp_beats && first_adr == exp_adr) else begin
                        mismatches++;
                        $display("MISMATCH at %0t ns: %h took %0d beats from %h, want %0d from %h",
                                 $time, e.addr, beats - e.beats, first_adr, exp_beats, exp_adr);
                    end
                end
            end
        end
        if (rstn && req_valid && req_ready) begin
            e.addr      = req.addr;
            e.fault     = (req.addr[1:0] != 2'b00);
            e.data      = e.fault ? 64'd0 : expected_pair(req.addr);
            e.kind      = cur_kind;
            e.acc_cycle = cycle;
            e.beats     = beats;
            exp_q.push_back(e);
        end
        if (wb_m2s.cyc && !cyc_d) begin
            first_adr = wb_m2s.adr;
        end
        cyc_d = wb_m2s.cyc;
        cycle++;
    end

    // drive a request and hold it until the handshake
    task automatic send(input logic [31:0] addr, input logic unc, input logic [1:0] kind);
        req.addr     = addr;
        req.uncached = unc;
        cur_kind     = kind;
        req_valid    = 1'b1;
        do @(posedge clk); while (!req_ready);
        #2;
    endtask

    task automatic drain_responses;
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_max) begin
            @(posedge clk);
            #2;
            waited++;
        end
    endtask

    task automatic fetch(input logic [31:0] addr, input logic unc, input logic [1:0] kind);
        send(addr, unc, kind);
        req_valid = 1'b0;
        drain_responses();
    endtask

    task automatic issue_barrier;
        ibar = 1'b1;
        @(posedge clk);
        #2;
        ibar = 1'b0;
    endtask

    // flush lands while the line is still on the bus
    task automatic flush_during_miss(input logic [31:0] addr);
        send(addr, 1'b0, K_LINE);
        req_valid = 1'b0;
        do @(posedge clk); while (!wb_m2s.cyc);
        #2;
        flush = 1'b1;
        exp_q.delete(exp_q.size() - 1);
        @(posedge clk);
        #2;
        flush = 1'b0;
        do @(posedge clk); while (wb_m2s.cyc);
        repeat (3) @(posedge clk);
        #2;
    endtask

    task automatic random_stream(input int n);
        logic [31:0] a;
        for (int i = 0; i < n; i++) begin
            a = 32'h0001_0000 + ($urandom_range(3, 0) << 12) + ($urandom_range(3, 0) << 6)
                + ($urandom_range(15, 0) << 2);   // 4 tags over 4 sets
            send(a, 1'b0, K_ANY);
        end
        req_valid = 1'b0;
        drain_responses();
    endtask

    initial begin
        seed_val  = $urandom(75469);
        rstn      = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        flush     = 1'b0;
        ibar      = 1'b0;
        cur_kind  = K_ANY;
        first_adr = '0;
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;

        fetch(32'h0002_0280, 1'b0, K_LINE);    // line A in set 10
        fetch(32'h0002_02a4, 1'b0, K_HIT);
        fetch(32'h0002_02bc, 1'b0, K_HIT);
        fetch(32'h0003_0280, 1'b0, K_LINE);    // B in the same set
        fetch(32'h0002_0288, 1'b0, K_HIT);
        fetch(32'h0004_0280, 1'b0, K_LINE);    // C evicts B
        fetch(32'h0002_0290, 1'b0, K_HIT);
        fetch(32'h0003_0284, 1'b0, K_LINE);
        fetch(32'h0005_0104, 1'b1, K_PAIR);    // uncached so never allocated
        fetch(32'h0005_0104, 1'b1, K_PAIR);
        fetch(32'h0002_0282, 1'b0, K_HIT);     // misaligned
        issue_barrier();
        fetch(32'h0002_0280, 1'b0, K_LINE);
        flush_during_miss(32'h0006_0300);
        fetch(32'h0006_0308, 1'b0, K_HIT);
        random_stream(n_rand);

        repeat (4) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            protocol_errors++;
            $display("%0d requests never got a response", exp_q.size());
        end
        $display("errors: %0d mismatches, %0d protocol errors", mismatches, protocol_errors);
        if (mismatches == 0 && protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("The run did not finish within %0d ns and was stopped", timeout_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/icache_pkg.sv
source/sdp_ram.sv
source/icache_way.sv
source/wb_line_fetcher.sv
source/icache.sv
source/fetch_top.sv
test/wb_rom_model.sv
test/tb_fetch_top.sv
